// File: filelist.f
verilog/ipv4_csum_pkg.sv
verilog/csum_verify_fsm.sv
verilog/header_word_counter.sv
verilog/csum_accumulator.sv
verilog/ttl_csum_update.sv
verilog/ipv4_csum_extern.sv
bench/ipv4_csum_props.sv
bench/tb_ipv4_csum_extern.sv

// File: Makefile
# Verilator build and run of the checksum helper testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ipv4_csum_extern
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

# build, run, then search the log for the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_ipv4_csum_extern.sv
// directed tests of the checksum helper, inputs change on the falling edge
// outputs are sampled on the falling edge too, stops at the first mismatch
module tb_ipv4_csum_extern;

    logic                        packet_data_in;
    logic                        reset;
    logic                        verify_req_valid;
    ipv4_csum_pkg::ipv4_header_t verify_header;
    logic                        verify_busy;
    logic                        verify_resp_valid;
    logic                        verify_ok;
    logic                        update_req_valid;
    ipv4_csum_pkg::csum_t        update_old_checksum;
    ipv4_csum_pkg::ttl_t         update_old_ttl;
    ipv4_csum_pkg::ttl_t         update_new_ttl;
    logic                        update_resp_valid;
    ipv4_csum_pkg::csum_t        update_new_checksum;
    logic [31:0]                 lfsr_state;

    ipv4_csum_extern i_ipv4_csum_extern (
        .packet_data_in      (packet_data_in),
        .reset               (reset),
        .verify_req_valid    (verify_req_valid),
        .verify_header       (verify_header),
        .verify_busy         (verify_busy),
        .verify_resp_valid   (verify_resp_valid),
        .verify_ok           (verify_ok),
        .update_req_valid    (update_req_valid),
        .update_old_checksum (update_old_checksum),
        .update_old_ttl      (update_old_ttl),
        .update_new_ttl      (update_new_ttl),
        .update_resp_valid   (update_resp_valid),
        .update_new_checksum (update_new_checksum)
    );

    initial begin
        packet_data_in = 1'b0;
        forever begin
            #20 packet_data_in = ~packet_data_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic ipv4_csum_pkg::csum_t get_word(
        input ipv4_csum_pkg::ipv4_header_t hdr,
        input int                          index
    );
        return hdr[(ipv4_csum_pkg::LAST_WORD_INDEX - index)*16 +: 16];
    endfunction

    function automatic ipv4_csum_pkg::ipv4_header_t put_word(
        input ipv4_csum_pkg::ipv4_header_t hdr,
        input int                          index,
        input ipv4_csum_pkg::csum_t        value
    );
        ipv4_csum_pkg::ipv4_header_t result;
        result = hdr;
        result[(ipv4_csum_pkg::LAST_WORD_INDEX - index)*16 +: 16] = value;
        return result;
    endfunction

    // wide total first, carries folded in at the end
    function automatic ipv4_csum_pkg::csum_t header_sum(input ipv4_csum_pkg::ipv4_header_t hdr);
        logic [31:0] total;
        total = '0;
        for (int i = 0; i < ipv4_csum_pkg::HEADER_WORDS; i++) begin
            total = total + {16'h0000, get_word(hdr, i)};
        end
        // ten words need two folds at most
        total = {16'h0000, total[15:0]} + {16'h0000, total[31:16]};
        total = {16'h0000, total[15:0]} + {16'h0000, total[31:16]};
        return total[15:0];
    endfunction

    // checksum field is word 5
    function automatic ipv4_csum_pkg::ipv4_header_t with_checksum(
        input ipv4_csum_pkg::ipv4_header_t hdr
    );
        ipv4_csum_pkg::ipv4_header_t cleared;
        cleared = put_word(hdr, 5, 16'h0000);
        return put_word(cleared, 5, ~header_sum(cleared));
    endfunction

    function automatic ipv4_csum_pkg::ipv4_header_t random_header();
        ipv4_csum_pkg::ipv4_header_t hdr;
        hdr = '0;
        for (int i = 0; i < ipv4_csum_pkg::HEADER_WORDS; i++) begin
            hdr = put_word(hdr, i, ipv4_csum_pkg::csum_t'(random_bits(16)));
        end
        // version 4 and ihl 5, word 0 never zero
        hdr[159:152] = 8'h45;
        return with_checksum(hdr);
    endfunction

    function automatic ipv4_csum_pkg::ipv4_header_t flip_bit(
        input ipv4_csum_pkg::ipv4_header_t hdr
    );
        int                          position;
        ipv4_csum_pkg::ipv4_header_t result;
        position = int'(random_bits(8)) % 160;
        result = hdr;
        result[position] = ~result[position];
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // check and failure helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    // one request, then wait for the strobe with a cycle limit
    task automatic run_verify(input ipv4_csum_pkg::ipv4_header_t hdr, input logic expected_ok);
        int cycles;
        @(negedge packet_data_in);
        check_value("verify_busy before request", 32'(verify_busy), 32'd0);
        verify_header    = hdr;
        verify_req_valid = 1'b1;
        @(negedge packet_data_in);
        verify_req_valid = 1'b0;
        cycles = 1;
        while (!verify_resp_valid && cycles < 2 * ipv4_csum_pkg::VERIFY_LATENCY) begin
            @(negedge packet_data_in);
            cycles++;
        end
        if (!verify_resp_valid) begin
            abort_run("no verify response arrived within the cycle limit");
        end
        check_value("verify latency", 32'(cycles), 32'(ipv4_csum_pkg::VERIFY_LATENCY));
        check_value("verify_ok", 32'(verify_ok), 32'(expected_ok));
    endtask

    task automatic reset_outputs_low();
        check_value("verify_busy after reset", 32'(verify_busy), 32'd0);
        check_value("verify_resp_valid after reset", 32'(verify_resp_valid), 32'd0);
        check_value("update_resp_valid after reset", 32'(update_resp_valid), 32'd0);
    endtask

    task automatic good_and_flipped_header();
        ipv4_csum_pkg::ipv4_header_t hdr;
        hdr = random_header();
        run_verify(hdr, 1'b1);
        run_verify(flip_bit(hdr), 1'b0);
    endtask

    // odd headers corrupted
    task automatic random_verify_batch();
        ipv4_csum_pkg::ipv4_header_t hdr;
        for (int i = 0; i < 20; i++) begin
            hdr = random_header();
            if (i % 2 == 1) begin
                hdr = flip_bit(hdr);
            end
            run_verify(hdr, header_sum(hdr) == ipv4_csum_pkg::CSUM_ALL_ONES);
        end
    endtask

    // request n driven at cycle n, its response due at cycle n + 2
    task automatic back_to_back_updates();
        ipv4_csum_pkg::csum_t        expected [30];
        ipv4_csum_pkg::ipv4_header_t hdr;
        ipv4_csum_pkg::csum_t        ttl_word;
        ipv4_csum_pkg::ttl_t         new_ttl;
        for (int cyc = 0; cyc < 33; cyc++) begin
            @(negedge packet_data_in);
            if (cyc >= ipv4_csum_pkg::UPDATE_LATENCY && cyc < 32) begin
                check_value("update_resp_valid", 32'(update_resp_valid), 32'd1);
                check_value("update_new_checksum", 32'(update_new_checksum),
                            32'(expected[cyc - ipv4_csum_pkg::UPDATE_LATENCY]));
            end else begin
                check_value("update_resp_valid idle", 32'(update_resp_valid), 32'd0);
            end
            if (cyc < 30) begin
                hdr      = random_header();
                new_ttl  = ipv4_csum_pkg::ttl_t'(random_bits(8));
                ttl_word = get_word(hdr, 4);
                // full recompute over the header with the new ttl
                expected[cyc] = get_word(with_checksum(put_word(hdr, 4,
                                         {new_ttl, ttl_word[7:0]})), 5);
                update_req_valid    = 1'b1;
                update_old_checksum = get_word(hdr, 5);
                update_old_ttl      = ttl_word[15:8];
                update_new_ttl      = new_ttl;
            end else begin
                update_req_valid = 1'b0;
            end
        end
    endtask

    // intruders in a sum cycle and in the respond cycle
    task automatic busy_request_dropped();
        ipv4_csum_pkg::ipv4_header_t first;
        int                          responses;
        int                          response_cycle;
        logic                        verdict;
        first          = random_header();
        responses      = 0;
        response_cycle = 0;
        verdict        = 1'b0;
        @(negedge packet_data_in);
        verify_header    = first;
        verify_req_valid = 1'b1;
        for (int cyc = 1; cyc <= 30; cyc++) begin
            @(negedge packet_data_in);
            verify_req_valid = 1'b0;
            if (verify_resp_valid) begin
                responses++;
                response_cycle = cyc;
                verdict        = verify_ok;
            end
            if (cyc == 5 || cyc == ipv4_csum_pkg::VERIFY_LATENCY) begin
                check_value("verify_busy at intruding request", 32'(verify_busy), 32'd1);
                verify_header    = flip_bit(random_header());
                verify_req_valid = 1'b1;
            end
        end
        check_value("verify responses", 32'(responses), 32'd1);
        check_value("verify response cycle", 32'(response_cycle),
                    32'(ipv4_csum_pkg::VERIFY_LATENCY));
        check_value("verify_ok of first header", 32'(verdict), 32'd1);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr_state          = 32'h89f2_d073;
        reset               = 1'b1;
        verify_req_valid    = 1'b0;
        verify_header       = '0;
        update_req_valid    = 1'b0;
        update_old_checksum = '0;
        update_old_ttl      = '0;
        update_new_ttl      = '0;
        repeat (5) @(negedge packet_data_in);
        reset = 1'b0;
        reset_outputs_low();
        good_and_flipped_header();
        random_verify_batch();
        back_to_back_updates();
        busy_request_dropped();
        // bound timing properties count their own failures
        if (i_ipv4_csum_extern.i_ipv4_csum_props.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("timing assertions failed during the run");
            $display("=== FAIL ===");
        end
        $finish;
    end

    // 22 verifies at their cycle limit, update stream, busy test, doubled
    initial begin
        int budget_cycles;
        budget_cycles = 5 + 22 * (2 * ipv4_csum_pkg::VERIFY_LATENCY + 2) + 33 + 32;
        budget_cycles = 2 * budget_cycles;
        #(budget_cycles * 40);
        $display("watchdog expired, the tests did not finish in time");
        $display("=== FAIL ===");
        $fatal(1);
    end

endmodule

// File: bench/ipv4_csum_props.sv
// timing rules of the checksum helper, bound into the top level
// verify latency holds only for requests taken while the engine is idle
module ipv4_csum_props (
    input logic packet_data_in,
    input logic reset,
    input logic verify_req_valid,
    input logic verify_busy,
    input logic verify_resp_valid,
    input logic update_req_valid,
    input logic update_resp_valid
);

    // failed properties so far, read by the testbench at the end of the run
    int failures = 0;

    ////////////////////////////////////////////////////////////
    // latency of both channels
    ////////////////////////////////////////////////////////////

    // accepted request, then the strobe a fixed number of edges later
    assert property (@(posedge packet_data_in) disable iff (reset)
        (verify_req_valid && !verify_busy)
            |-> ##(ipv4_csum_pkg::VERIFY_LATENCY) verify_resp_valid)
        else begin
            failures++;
            $error("verify response missing after an accepted request");
        end

    // update pipe never stalls
    assert property (@(posedge packet_data_in) disable iff (reset)
        update_req_valid |-> ##(ipv4_csum_pkg::UPDATE_LATENCY) update_resp_valid)
        else begin
            failures++;
            $error("update response missing after a request");
        end

    ////////////////////////////////////////////////////////////
    // reset values
    ////////////////////////////////////////////////////////////

    assert property (@(posedge packet_data_in)
        reset |=> (!verify_busy && !verify_resp_valid && !update_resp_valid))
        else begin
            failures++;
            $error("busy or a response strobe high after reset");
        end

endmodule

bind ipv4_csum_extern ipv4_csum_props i_ipv4_csum_props (
    .packet_data_in    (packet_data_in),
    .reset             (reset),
    .verify_req_valid  (verify_req_valid),
    .verify_busy       (verify_busy),
    .verify_resp_valid (verify_resp_valid),
    .update_req_valid  (update_req_valid),
    .update_resp_valid (update_resp_valid)
);

// File: verilog/ipv4_csum_extern.sv
// checksum verify and ttl update externs, strobes only, no back-pressure
// verify answers after 12 cycles and drops requests while busy; update after 2
module ipv4_csum_extern (
    input  logic                        packet_data_in,
    input  logic                        reset,
    // verify channel
    input  logic                        verify_req_valid,
    input  ipv4_csum_pkg::ipv4_header_t verify_header,
    output logic                        verify_busy,
    output logic                        verify_resp_valid,
    output logic                        verify_ok,
    // update channel
    input  logic                        update_req_valid,
    input  ipv4_csum_pkg::csum_t        update_old_checksum,
    input  ipv4_csum_pkg::ttl_t         update_old_ttl,
    input  ipv4_csum_pkg::ttl_t         update_new_ttl,
    output logic                        update_resp_valid,
    output ipv4_csum_pkg::csum_t        update_new_checksum
);

    ////////////////////////////////////////////////////////////
    // verify engine
    ////////////////////////////////////////////////////////////

    logic                       capture;
    logic                       count_clear;
    logic                       count_enable;
    logic                       compare;
    logic                       respond;
    ipv4_csum_pkg::word_index_t word_index;
    logic                       word_last;

    // sequencing
    csum_verify_fsm i_csum_verify_fsm (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .req_valid      (verify_req_valid),
        .word_last      (word_last),
        .capture        (capture),
        .count_clear    (count_clear),
        .count_enable   (count_enable),
        .compare        (compare),
        .busy           (verify_busy),
        .respond        (respond)
    );

    // word select
    header_word_counter i_header_word_counter (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .clear          (count_clear),
        .enable         (count_enable),
        .word_index     (word_index),
        .word_last      (word_last)
    );

    // datapath, sums while the counter runs
    csum_accumulator i_csum_accumulator (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .capture        (capture),
        .header         (verify_header),
        .accumulate     (count_enable),
        .word_index     (word_index),
        .compare        (compare),
        .verify_ok      (verify_ok)
    );

    assign verify_resp_valid = respond;

    ////////////////////////////////////////////////////////////
    // update pipeline
    ////////////////////////////////////////////////////////////

    ttl_csum_update i_ttl_csum_update (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .req_valid      (update_req_valid),
        .old_checksum   (update_old_checksum),
        .old_ttl        (update_old_ttl),
        .new_ttl        (update_new_ttl),
        .resp_valid     (update_resp_valid),
        .new_checksum   (update_new_checksum)
    );

endmodule

// File: verilog/ttl_csum_update.sv
// incremental checksum update after a ttl change, hc' = ~(~hc + ~m + m')
// fully pipelined, takes a request every cycle, no stall
module ttl_csum_update (
    input  logic                 packet_data_in,
    input  logic                 reset,
    input  logic                 req_valid,
    input  ipv4_csum_pkg::csum_t old_checksum,
    input  ipv4_csum_pkg::ttl_t  old_ttl,
    input  ipv4_csum_pkg::ttl_t  new_ttl,
    output logic                 resp_valid,
    output ipv4_csum_pkg::csum_t new_checksum
);

    ////////////////////////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////////////////////////

    // ttl is the upper byte of header word 4, protocol below it
    ipv4_csum_pkg::csum_t old_ttl_word;
    ipv4_csum_pkg::csum_t s1_sum;
    ipv4_csum_pkg::csum_t s1_sum_q;
    ipv4_csum_pkg::ttl_t  s1_new_ttl_q;
    logic                 s1_valid_q;
    ipv4_csum_pkg::csum_t s2_sum;

    assign old_ttl_word = {old_ttl, 8'h00};

    // ~hc + ~m
    assign s1_sum = ipv4_csum_pkg::ones_add(~old_checksum, ~old_ttl_word);

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid;
        end
    end

    // payload rides along with the valid bit
    always_ff @(posedge packet_data_in) begin
        s1_sum_q     <= s1_sum;
        s1_new_ttl_q <= new_ttl;
    end

    ////////////////////////////////////////////////////////////
    // stage 2
    ////////////////////////////////////////////////////////////

    // + m', new ttl word with a zero low byte
    assign s2_sum = ipv4_csum_pkg::ones_add(s1_sum_q, {s1_new_ttl_q, 8'h00});

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s1_valid_q;
        end
    end

    // final complement gives the field value
    always_ff @(posedge packet_data_in) begin
        new_checksum <= ~s2_sum;
    end

endmodule

// File: verilog/csum_accumulator.sv
// serial ones' complement sum of a captured header, one word per cycle
// verdict stays stable from the respond cycle until the next compare
module csum_accumulator (
    input  logic                        packet_data_in,
    input  logic                        reset,
    input  logic                        capture,
    input  ipv4_csum_pkg::ipv4_header_t header,
    input  logic                        accumulate,
    input  ipv4_csum_pkg::word_index_t  word_index,
    input  logic                        compare,
    output logic                        verify_ok
);

    ////////////////////////////////////////////////////////////
    // captured header
    ////////////////////////////////////////////////////////////

    ipv4_csum_pkg::ipv4_header_t header_q;
    ipv4_csum_pkg::csum_t        header_words [ipv4_csum_pkg::HEADER_WORDS];
    ipv4_csum_pkg::csum_t        sum_q;
    ipv4_csum_pkg::csum_t        word_sel;

    // header held for the whole sum phase
    always_ff @(posedge packet_data_in) begin
        if (capture) begin
            header_q <= header;
        end
    end

    // split into words, word 0 from the msbs
    always_comb begin
        for (int i = 0; i < ipv4_csum_pkg::HEADER_WORDS; i++) begin
            header_words[i] = header_q[(ipv4_csum_pkg::LAST_WORD_INDEX - i)*16 +: 16];
        end
    end

    // word picked by the counter
    assign word_sel = header_words[word_index];

    ////////////////////////////////////////////////////////////
    // running sum and verdict
    ////////////////////////////////////////////////////////////

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            sum_q     <= '0;
            verify_ok <= 1'b0;
        end else begin
            if (capture) begin
                // fresh sum for the new header
                sum_q <= '0;
            end else if (accumulate) begin
                // carry folded back every cycle
                sum_q <= ipv4_csum_pkg::ones_add(sum_q, word_sel);
            end
            // checksum field included, so a good header sums to all ones
            if (compare) begin
                verify_ok <= (sum_q == ipv4_csum_pkg::CSUM_ALL_ONES);
            end
        end
    end

endmodule

// File: verilog/header_word_counter.sv
// steps through the header word indices while enabled
// runs one past 9 on the last sum cycle, the value is not used then
module header_word_counter (
    input  logic                       packet_data_in,
    input  logic                       reset,
    input  logic                       clear,
    input  logic                       enable,
    output ipv4_csum_pkg::word_index_t word_index,
    output logic                       word_last
);

    ////////////////////////////////////////////////////////////
    // index register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            word_index <= '0;
        end else if (clear) begin
            // restart at word 0 for a new header
            word_index <= '0;
        end else if (enable) begin
            word_index <= word_index + 4'd1;
        end
    end

    // last word flag, comb so the fsm leaves sum on this cycle
    assign word_last =
        (word_index == ipv4_csum_pkg::word_index_t'(ipv4_csum_pkg::LAST_WORD_INDEX));

endmodule

// File: verilog/csum_verify_fsm.sv
// one verify request at a time; requests seen outside idle are dropped
// requester has to watch busy, there is no ready handshake
module csum_verify_fsm (
    input  logic packet_data_in,
    input  logic reset,
    input  logic req_valid,
    input  logic word_last,
    output logic capture,
    output logic count_clear,
    output logic count_enable,
    output logic compare,
    output logic busy,
    output logic respond
);

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    ipv4_csum_pkg::verify_state_t state;
    ipv4_csum_pkg::verify_state_t state_next;

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            state <= ipv4_csum_pkg::verify_idle;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ipv4_csum_pkg::verify_idle: begin
                // accept only here
                if (req_valid) begin
                    state_next = ipv4_csum_pkg::verify_sum;
                end
            end
            ipv4_csum_pkg::verify_sum: begin
                // ten words, leave after the one at index 9
                if (word_last) begin
                    state_next = ipv4_csum_pkg::verify_compare;
                end
            end
            ipv4_csum_pkg::verify_compare: begin
                state_next = ipv4_csum_pkg::verify_respond;
            end
            ipv4_csum_pkg::verify_respond: begin
                state_next = ipv4_csum_pkg::verify_idle;
            end
            default: begin
                state_next = ipv4_csum_pkg::verify_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control strobes
    ////////////////////////////////////////////////////////////

    // capture header and zero the index in the accepting cycle
    assign capture      = (state == ipv4_csum_pkg::verify_idle) && req_valid;
    assign count_clear  = (state == ipv4_csum_pkg::verify_idle) && req_valid;
    // one word added per sum cycle
    assign count_enable = (state == ipv4_csum_pkg::verify_sum);
    assign compare      = (state == ipv4_csum_pkg::verify_compare);
    // response strobe lines up with the registered verdict
    assign respond      = (state == ipv4_csum_pkg::verify_respond);
    assign busy         = (state != ipv4_csum_pkg::verify_idle);

endmodule

// File: verilog/ipv4_csum_pkg.sv
// shared widths, state encoding and timing constants of the checksum helper
// headers carry no options, so a header is always exactly ten 16-bit words
package ipv4_csum_pkg;

    ////////////////////////////////////////////////////////////
    // header geometry
    ////////////////////////////////////////////////////////////

    // number of 16-bit words in an option-less header
    localparam int HEADER_WORDS = 10;
    localparam int LAST_WORD_INDEX = HEADER_WORDS - 1;

    // word 0 sits in the top 16 bits
    typedef logic [HEADER_WORDS*16-1:0] ipv4_header_t;

    // checksum or one header word
    typedef logic [15:0] csum_t;
    typedef logic [7:0] ttl_t;

    // index of a header word, 0 to 9
    typedef logic [3:0] word_index_t;

    // ones' complement sum over a valid header
    localparam csum_t CSUM_ALL_ONES = 16'hffff;

    ////////////////////////////////////////////////////////////
    // timing seen at the top level
    ////////////////////////////////////////////////////////////

    // accepted verify request to response strobe, in cycles
    localparam int VERIFY_LATENCY = 12;
    // update request to response strobe, in cycles
    localparam int UPDATE_LATENCY = 2;

    // verify engine states
    typedef enum logic [1:0] {
        verify_idle,
        verify_sum,
        verify_compare,
        verify_respond
    } verify_state_t;

    // 16-bit ones' complement add with end-around carry
    // a single fold is enough, the folded result cannot carry again
    function automatic csum_t ones_add(input csum_t a, input csum_t b);
        logic [16:0] total;
        total = {1'b0, a} + {1'b0, b};
        return total[15:0] + csum_t'(total[16]);
    endfunction

endpackage
